//--- verilog/race_pkg.sv
`default_nettype none

package race_pkg;

    typedef logic [9:0]  coord_t;
    typedef logic [11:0] rgb_t;
    typedef logic [1:0]  map_index_t;
    typedef logic [14:0] map_addr_t;

    // ========================================================================
    // 640x480 scan timing at 25 MHz
    // ========================================================================
    localparam int H_VISIBLE    = 640;
    localparam int H_SYNC_START = 656;
    localparam int H_SYNC_LEN   = 96;
    localparam int H_TOTAL      = 800;
    localparam int V_VISIBLE    = 480;
    localparam int V_SYNC_START = 490;
    localparam int V_SYNC_LEN   = 2;
    localparam int V_TOTAL      = 525;

    // ========================================================================
    // screen regions and world geometry
    // ========================================================================
    localparam int HALF_WIDTH = 320;
    // rows HUD_TOP-1 and HUD_TOP form the separator
    localparam int HUD_TOP    = 360;
    localparam int MAP_W      = 160;
    localparam int MAP_H      = 120;
    localparam int VIEW_OFS_X = 40;
    localparam int VIEW_OFS_Y = 60;
    localparam int MINI_X0    = 240;
    localparam int MINI_X1    = 400;
    localparam int SELF_CX    = 160;
    localparam int SELF_CY    = 180;
    localparam int CAR_HALF   = 37;
    localparam int DOT_HALF   = 1;

    // colours, track classes 0 to 3
    localparam rgb_t PALETTE [4] = '{12'h000, 12'h6B4, 12'h888, 12'hFC0};

    localparam rgb_t OUT_BOUND_COLOR = 12'h6B4;
    localparam rgb_t SEPARATOR_COLOR = 12'hFFF;
    localparam rgb_t HUD_COLOR       = 12'h444;
    localparam rgb_t P1_COLOR        = 12'hF00;
    localparam rgb_t P2_COLOR        = 12'h00F;

    // decode, execute and compose registers
    localparam int PIPE_DEPTH = 3;

endpackage

`default_nettype wire

//--- verilog/scan_if.sv
`timescale 1ns/1ns
`default_nettype none

interface scan_if
    import race_pkg::*;
();

    // region flags
    logic   visible;
    logic   hud_sep;
    logic   in_hud;
    logic   in_minimap;
    logic   v_sep;
    logic   left_half;
    // position within the half and the players seen from it
    coord_t rel_x;
    coord_t row;
    coord_t own_x;
    coord_t own_y;
    coord_t rival_x;
    coord_t rival_y;
    // world cell under the minimap scan
    coord_t mini_x;
    coord_t mini_y;

    modport decoder (
        output visible, hud_sep, in_hud, in_minimap, v_sep, left_half,
        output rel_x, row, own_x, own_y, rival_x, rival_y, mini_x, mini_y
    );

    modport executor (
        input visible, hud_sep, in_hud, in_minimap, v_sep, left_half,
        input rel_x, row, own_x, own_y, rival_x, rival_y, mini_x, mini_y
    );

endinterface

`default_nettype wire

//--- verilog/layer_if.sv
`timescale 1ns/1ns
`default_nettype none

interface layer_if
    import race_pkg::*;
();

    // region flags, one stage later than scan_if
    logic       visible;
    logic       hud_sep;
    logic       in_hud;
    logic       in_minimap;
    logic       v_sep;
    logic       left_half;
    // layer hits for this pixel
    logic       self_hit;
    logic       rival_hit;
    logic       out_of_map;
    logic       p1_dot;
    logic       p2_dot;
    // track classes straight from the memory read ports
    map_index_t view_index;
    map_index_t mini_index;

    modport executor (
        output visible, hud_sep, in_hud, in_minimap, v_sep, left_half,
        output self_hit, rival_hit, out_of_map, p1_dot, p2_dot,
        output view_index, mini_index
    );

    modport composer (
        input visible, hud_sep, in_hud, in_minimap, v_sep, left_half,
        input self_hit, rival_hit, out_of_map, p1_dot, p2_dot,
        input view_index, mini_index
    );

endinterface

`default_nettype wire

//--- verilog/vga_timing.sv
`timescale 1ns/1ns
`default_nettype none

module vga_timing
    import race_pkg::*;
(
    input  logic   clk_25MHz,
    input  logic   rst,
    output coord_t h_cnt,
    output coord_t v_cnt,
    output logic   visible,
    output logic   hsync,
    output logic   vsync
);

    coord_t h_next;
    coord_t v_next;

    // next scan position, wraps at the end of line and frame
    always_comb begin
        h_next = h_cnt + 10'd1;
        v_next = v_cnt;
        if (h_cnt == coord_t'(H_TOTAL - 1)) begin
            h_next = '0;
            if (v_cnt == coord_t'(V_TOTAL - 1)) begin
                v_next = '0;
            end else begin
                v_next = v_cnt + 10'd1;
            end
        end
    end

    // flags decoded from the next position so they line up with the counters
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            h_cnt   <= '0;
            v_cnt   <= '0;
            visible <= 1'b0;
            hsync   <= 1'b1;
            vsync   <= 1'b1;
        end else begin
            h_cnt   <= h_next;
            v_cnt   <= v_next;
            visible <= (h_next < coord_t'(H_VISIBLE)) && (v_next < coord_t'(V_VISIBLE));
            hsync   <= !((h_next >= H_SYNC_START) && (h_next < H_SYNC_START + H_SYNC_LEN));
            vsync   <= !((v_next >= V_SYNC_START) && (v_next < V_SYNC_START + V_SYNC_LEN));
        end
    end

endmodule

`default_nettype wire

//--- verilog/track_ram.sv
`timescale 1ns/1ns
`default_nettype none

module track_ram #(
    parameter int DEPTH = 19200
) (
    input  logic        clk_25MHz,
    // loader side
    input  logic        we,
    input  logic [14:0] waddr,
    input  logic [1:0]  wdata,
    // main view read
    input  logic [14:0] view_addr,
    output logic [1:0]  view_data,
    // minimap read
    input  logic [14:0] mini_addr,
    output logic [1:0]  mini_data
);

    // one track class per world cell, row major
    logic [1:0] mem [DEPTH];

    always_ff @(posedge clk_25MHz) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // two independent synchronous read ports
    always_ff @(posedge clk_25MHz) begin
        view_data <= mem[view_addr];
        mini_data <= mem[mini_addr];
    end

endmodule

`default_nettype wire

//--- verilog/scan_decode.sv
`timescale 1ns/1ns
`default_nettype none

module scan_decode
    import race_pkg::*;
(
    input  logic    clk_25MHz,
    input  logic    rst,
    input  coord_t  h_cnt,
    input  coord_t  v_cnt,
    input  logic    visible,
    input  coord_t  p1_x,
    input  coord_t  p1_y,
    input  coord_t  p2_x,
    input  coord_t  p2_y,
    scan_if.decoder scan
);

    logic   left;
    logic   in_hud;
    coord_t rel_x;

    assign left   = (h_cnt < coord_t'(HALF_WIDTH));
    assign in_hud = (v_cnt >= coord_t'(HUD_TOP));
    // right half counts from its own left edge
    assign rel_x  = left ? h_cnt : h_cnt - coord_t'(HALF_WIDTH);

    // ========================================================================
    // region flags
    // ========================================================================
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            scan.visible    <= 1'b0;
            scan.hud_sep    <= 1'b0;
            scan.in_hud     <= 1'b0;
            scan.in_minimap <= 1'b0;
            scan.v_sep      <= 1'b0;
            scan.left_half  <= 1'b0;
        end else begin
            scan.visible    <= visible;
            scan.hud_sep    <= (v_cnt == coord_t'(HUD_TOP - 1)) || (v_cnt == coord_t'(HUD_TOP));
            scan.in_hud     <= in_hud;
            scan.in_minimap <= in_hud && (h_cnt >= coord_t'(MINI_X0))
                               && (h_cnt < coord_t'(MINI_X1));
            scan.v_sep      <= (h_cnt == coord_t'(HALF_WIDTH - 1))
                               || (h_cnt == coord_t'(HALF_WIDTH));
            scan.left_half  <= left;
        end
    end

    // ========================================================================
    // view selection and minimap cell
    // ========================================================================
    always_ff @(posedge clk_25MHz) begin
        scan.rel_x <= rel_x;
        scan.row   <= v_cnt;
        if (left) begin
            // player 1 owns the left view
            scan.own_x   <= p1_x;
            scan.own_y   <= p1_y;
            scan.rival_x <= p2_x;
            scan.rival_y <= p2_y;
        end else begin
            scan.own_x   <= p2_x;
            scan.own_y   <= p2_y;
            scan.rival_x <= p1_x;
            scan.rival_y <= p1_y;
        end
        // minimap is one screen pixel per world cell
        scan.mini_x <= h_cnt - coord_t'(MINI_X0);
        scan.mini_y <= v_cnt - coord_t'(HUD_TOP);
    end

endmodule

`default_nettype wire

//--- verilog/layer_execute.sv
`timescale 1ns/1ns
`default_nettype none

module layer_execute
    import race_pkg::*;
(
    input  logic     clk_25MHz,
    input  logic     rst,
    scan_if.executor scan,
    input  coord_t   p1_x,
    input  coord_t   p1_y,
    input  coord_t   p2_x,
    input  coord_t   p2_y,
    input  logic       map_we,
    input  map_addr_t  map_addr,
    input  map_index_t map_wdata,
    layer_if.executor  layer
);

    coord_t             view_col;
    coord_t             view_row;
    logic               view_out;
    map_addr_t          view_addr;
    map_addr_t          mini_addr;
    logic signed [13:0] rival_cx;
    logic signed [13:0] rival_cy;
    logic signed [13:0] off_x;
    logic signed [13:0] off_y;
    logic               self_c;
    logic               rival_c;
    logic               p1_dot_c;
    logic               p2_dot_c;

    function automatic coord_t abs_diff(input coord_t a, input coord_t b);
        return (a >= b) ? a - b : b - a;
    endfunction

    // world cell at four-times zoom, wraps modulo 1024
    assign view_col  = (scan.rel_x >> 2) + scan.own_x - coord_t'(VIEW_OFS_X);
    assign view_row  = (scan.row >> 2) + scan.own_y - coord_t'(VIEW_OFS_Y);
    assign view_out  = (view_col >= coord_t'(MAP_W)) || (view_row >= coord_t'(MAP_H));
    assign view_addr = view_out ? '0 : map_addr_t'(view_row * MAP_W + view_col);
    assign mini_addr = scan.in_minimap ? map_addr_t'(scan.mini_y * MAP_W + scan.mini_x) : '0;

    // self car sits fixed in the middle of the half
    assign self_c = (scan.rel_x >= coord_t'(SELF_CX - CAR_HALF))
                    && (scan.rel_x <= coord_t'(SELF_CX + CAR_HALF))
                    && (scan.row >= coord_t'(SELF_CY - CAR_HALF))
                    && (scan.row <= coord_t'(SELF_CY + CAR_HALF));

    // rival centre may land off screen, so the box test is signed
    assign rival_cx = 14'(SELF_CX)
                      + (($signed({4'b0, scan.rival_x}) - $signed({4'b0, scan.own_x})) <<< 2);
    assign rival_cy = 14'(SELF_CY)
                      + (($signed({4'b0, scan.rival_y}) - $signed({4'b0, scan.own_y})) <<< 2);
    assign off_x    = $signed({4'b0, scan.rel_x}) - rival_cx;
    assign off_y    = $signed({4'b0, scan.row}) - rival_cy;
    assign rival_c  = (off_x >= -CAR_HALF) && (off_x <= CAR_HALF)
                      && (off_y >= -CAR_HALF) && (off_y <= CAR_HALF);

    assign p1_dot_c = (abs_diff(scan.mini_x, p1_x) <= coord_t'(DOT_HALF))
                      && (abs_diff(scan.mini_y, p1_y) <= coord_t'(DOT_HALF));
    assign p2_dot_c = (abs_diff(scan.mini_x, p2_x) <= coord_t'(DOT_HALF))
                      && (abs_diff(scan.mini_y, p2_y) <= coord_t'(DOT_HALF));

    // read registers inside the memory line up with the hit registers
    track_ram #(
        .DEPTH (MAP_W * MAP_H)
    ) track_ram_inst (
        .clk_25MHz (clk_25MHz),
        .we        (map_we),
        .waddr     (map_addr),
        .wdata     (map_wdata),
        .view_addr (view_addr),
        .view_data (layer.view_index),
        .mini_addr (mini_addr),
        .mini_data (layer.mini_index)
    );

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            layer.visible    <= 1'b0;
            layer.hud_sep    <= 1'b0;
            layer.in_hud     <= 1'b0;
            layer.in_minimap <= 1'b0;
            layer.v_sep      <= 1'b0;
            layer.left_half  <= 1'b0;
            layer.self_hit   <= 1'b0;
            layer.rival_hit  <= 1'b0;
            layer.out_of_map <= 1'b0;
            layer.p1_dot     <= 1'b0;
            layer.p2_dot     <= 1'b0;
        end else begin
            layer.visible    <= scan.visible;
            layer.hud_sep    <= scan.hud_sep;
            layer.in_hud     <= scan.in_hud;
            layer.in_minimap <= scan.in_minimap;
            layer.v_sep      <= scan.v_sep;
            layer.left_half  <= scan.left_half;
            layer.self_hit   <= self_c;
            layer.rival_hit  <= rival_c;
            layer.out_of_map <= view_out;
            layer.p1_dot     <= p1_dot_c;
            layer.p2_dot     <= p2_dot_c;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pixel_compose.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_compose
    import race_pkg::*;
(
    input  logic      clk_25MHz,
    input  logic      rst,
    layer_if.composer layer,
    output logic [3:0] vga_red,
    output logic [3:0] vga_green,
    output logic [3:0] vga_blue
);

    rgb_t own_color;
    rgb_t rival_color;
    rgb_t color_next;
    rgb_t rgb_q;

    // the owner of a half is player 1 on the left
    assign own_color   = layer.left_half ? P1_COLOR : P2_COLOR;
    assign rival_color = layer.left_half ? P2_COLOR : P1_COLOR;

    // ========================================================================
    // colour priority, first match wins
    // ========================================================================
    always_comb begin
        if (!layer.visible) begin
            color_next = '0;
        end else if (layer.hud_sep) begin
            color_next = SEPARATOR_COLOR;
        end else if (layer.in_hud && layer.in_minimap) begin
            if (layer.p1_dot) begin
                color_next = P1_COLOR;
            end else if (layer.p2_dot) begin
                color_next = P2_COLOR;
            end else begin
                color_next = PALETTE[layer.mini_index];
            end
        end else if (layer.in_hud) begin
            color_next = HUD_COLOR;
        end else if (layer.v_sep) begin
            color_next = SEPARATOR_COLOR;
        end else if (layer.self_hit) begin
            color_next = own_color;
        end else if (layer.rival_hit) begin
            color_next = rival_color;
        end else if (layer.out_of_map) begin
            color_next = OUT_BOUND_COLOR;
        end else begin
            color_next = PALETTE[layer.view_index];
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            rgb_q <= '0;
        end else begin
            rgb_q <= color_next;
        end
    end

    assign vga_red   = rgb_q[11:8];
    assign vga_green = rgb_q[7:4];
    assign vga_blue  = rgb_q[3:0];

endmodule

`default_nettype wire

//--- verilog/split_screen_top.sv
`timescale 1ns/1ns
`default_nettype none

module split_screen_top
    import race_pkg::*;
(
    input  logic       clk_25MHz,
    input  logic       rst,
    // player world positions
    input  coord_t     p1_x,
    input  coord_t     p1_y,
    input  coord_t     p2_x,
    input  coord_t     p2_y,
    // track loader
    input  logic       map_we,
    input  map_addr_t  map_addr,
    input  map_index_t map_wdata,
    // VGA
    output logic [3:0] vga_red,
    output logic [3:0] vga_green,
    output logic [3:0] vga_blue,
    output logic       hsync,
    output logic       vsync
);

    coord_t                h_cnt;
    coord_t                v_cnt;
    logic                  visible;
    logic                  hsync_raw;
    logic                  vsync_raw;
    logic [PIPE_DEPTH-1:0] hsync_pipe;
    logic [PIPE_DEPTH-1:0] vsync_pipe;

    scan_if  scan_bus ();
    layer_if layer_bus ();

    vga_timing vga_timing_inst (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .h_cnt     (h_cnt),
        .v_cnt     (v_cnt),
        .visible   (visible),
        .hsync     (hsync_raw),
        .vsync     (vsync_raw)
    );

    scan_decode scan_decode_inst (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .h_cnt     (h_cnt),
        .v_cnt     (v_cnt),
        .visible   (visible),
        .p1_x      (p1_x),
        .p1_y      (p1_y),
        .p2_x      (p2_x),
        .p2_y      (p2_y),
        .scan      (scan_bus.decoder)
    );

    layer_execute layer_execute_inst (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .scan      (scan_bus.executor),
        .p1_x      (p1_x),
        .p1_y      (p1_y),
        .p2_x      (p2_x),
        .p2_y      (p2_y),
        .map_we    (map_we),
        .map_addr  (map_addr),
        .map_wdata (map_wdata),
        .layer     (layer_bus.executor)
    );

    pixel_compose pixel_compose_inst (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .layer     (layer_bus.composer),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue)
    );

    // syncs ride alongside the pixel pipeline, idle high
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            hsync_pipe <= '1;
            vsync_pipe <= '1;
        end else begin
            hsync_pipe <= {hsync_pipe[PIPE_DEPTH-2:0], hsync_raw};
            vsync_pipe <= {vsync_pipe[PIPE_DEPTH-2:0], vsync_raw};
        end
    end

    assign hsync = hsync_pipe[PIPE_DEPTH-1];
    assign vsync = vsync_pipe[PIPE_DEPTH-1];

endmodule

`default_nettype wire

//--- tests/split_screen_props.sv
`timescale 1ns/1ns
`default_nettype none

module split_screen_props
    import race_pkg::*;
(
    input logic       clk_25MHz,
    input logic       rst,
    input logic       visible,
    input logic       hsync,
    input logic       vsync,
    input logic [3:0] vga_red,
    input logic [3:0] vga_green,
    input logic [3:0] vga_blue
);

    // cycles in the current sync pulse and since the last falling edge
    int unsigned hs_low;
    int unsigned hs_period;
    int unsigned vs_low;
    int unsigned vs_period;
    logic        h_seen;
    logic        v_seen;
    bit          violation = 1'b0;

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            hs_low    <= 0;
            hs_period <= 0;
            vs_low    <= 0;
            vs_period <= 0;
            h_seen    <= 1'b0;
            v_seen    <= 1'b0;
        end else begin
            hs_low    <= hsync ? 0 : hs_low + 1;
            hs_period <= (!hsync && hs_low == 0) ? 1 : hs_period + 1;
            vs_low    <= vsync ? 0 : vs_low + 1;
            vs_period <= (!vsync && vs_low == 0) ? 1 : vs_period + 1;
            h_seen    <= h_seen || !hsync;
            v_seen    <= v_seen || !vsync;
        end
    end

    // ========================================================================
    // sync shape and blanking at the ports
    // ========================================================================
    syncs_idle: assert property (@(posedge clk_25MHz) rst |=> (hsync && vsync))
        else begin violation = 1'b1; $error("syncs not high after reset"); end

    hsync_width: assert property (@(posedge clk_25MHz) disable iff (rst)
        $rose(hsync) |-> (hs_low == H_SYNC_LEN))
        else begin violation = 1'b1; $error("hsync pulse width wrong"); end

    hsync_period: assert property (@(posedge clk_25MHz) disable iff (rst)
        ($fell(hsync) && h_seen) |-> (hs_period == H_TOTAL))
        else begin violation = 1'b1; $error("hsync period wrong"); end

    vsync_width: assert property (@(posedge clk_25MHz) disable iff (rst)
        $rose(vsync) |-> (vs_low == V_SYNC_LEN * H_TOTAL))
        else begin violation = 1'b1; $error("vsync pulse width wrong"); end

    vsync_period: assert property (@(posedge clk_25MHz) disable iff (rst)
        ($fell(vsync) && v_seen) |-> (vs_period == V_TOTAL * H_TOTAL))
        else begin violation = 1'b1; $error("vsync period wrong"); end

    // pixel at the ports left the counters PIPE_DEPTH cycles ago
    blank_black: assert property (@(posedge clk_25MHz) disable iff (rst)
        !$past(visible, PIPE_DEPTH) |-> ({vga_red, vga_green, vga_blue} == 12'h000))
        else begin violation = 1'b1; $error("colour outside the visible area"); end

endmodule

`default_nettype wire

//--- tests/split_screen_tb.sv
`timescale 1ns/1ns
`default_nettype none

module split_screen_tb
    import race_pkg::*;
();

    localparam int LOAD_CYCLES  = MAP_W * MAP_H;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int CYCLE_LIMIT  = 4 * FRAME_CYCLES + LOAD_CYCLES + 64;
    localparam int RAND_SEED    = 66277;

    // one scene per checked frame
    // rival close by, opposite map corners, both on one spot
    localparam coord_t SCENE_P1X [3] = '{10'd80, 10'd5, 10'd100};
    localparam coord_t SCENE_P1Y [3] = '{10'd60, 10'd3, 10'd50};
    localparam coord_t SCENE_P2X [3] = '{10'd90, 10'd155, 10'd100};
    localparam coord_t SCENE_P2Y [3] = '{10'd65, 10'd117, 10'd50};

    localparam rgb_t TRACK_COLORS [4] = '{12'h000, 12'h6B4, 12'h888, 12'hFC0};

    logic       clk_25MHz;
    logic       rst;
    coord_t     p1_x;
    coord_t     p1_y;
    coord_t     p2_x;
    coord_t     p2_y;
    logic       map_we;
    map_addr_t  map_addr;
    map_index_t map_wdata;
    logic [3:0] vga_red;
    logic [3:0] vga_green;
    logic [3:0] vga_blue;
    logic       hsync;
    logic       vsync;

    map_index_t track_copy [MAP_W * MAP_H];
    int         cycles = 0;
    int         frames = 0;
    int         scan_col = 0;
    int         scan_row = 0;
    logic       col_known = 1'b0;
    logic       row_known = 1'b0;
    logic       hs_prev = 1'b1;
    logic       vs_prev = 1'b1;
    logic       vs_fell = 1'b0;
    logic       loaded = 1'b0;

    split_screen_top split_screen_top_inst (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .p1_x      (p1_x),
        .p1_y      (p1_y),
        .p2_x      (p2_x),
        .p2_y      (p2_y),
        .map_we    (map_we),
        .map_addr  (map_addr),
        .map_wdata (map_wdata),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue),
        .hsync     (hsync),
        .vsync     (vsync)
    );

    bind split_screen_top split_screen_props props_inst (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .visible   (visible),
        .hsync     (hsync),
        .vsync     (vsync),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue)
    );

    initial begin
        clk_25MHz = 1'b0;
        forever #20 clk_25MHz = ~clk_25MHz;
    end

    function automatic int distance(input int a, input int b);
        return (a >= b) ? a - b : b - a;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // ========================================================================
    // reference colour for one screen pixel
    // ========================================================================
    task automatic model_pixel(input int row, input int col, output rgb_t color,
                               output string name);
        logic left;
        int   rel;
        int   ox;
        int   oy;
        int   rx;
        int   ry;
        int   mx;
        int   my;
        int   wc;
        int   wr;
        int   cx;
        int   cy;
        left = (col < HALF_WIDTH);
        rel  = left ? col : col - HALF_WIDTH;
        ox   = left ? int'(p1_x) : int'(p2_x);
        oy   = left ? int'(p1_y) : int'(p2_y);
        rx   = left ? int'(p2_x) : int'(p1_x);
        ry   = left ? int'(p2_y) : int'(p1_y);
        mx   = col - MINI_X0;
        my   = row - HUD_TOP;
        // world cell at four-times zoom, wraps at 1024
        wc   = (rel / 4 + ox - VIEW_OFS_X) & 1023;
        wr   = (row / 4 + oy - VIEW_OFS_Y) & 1023;
        cx   = SELF_CX + 4 * (rx - ox);
        cy   = SELF_CY + 4 * (ry - oy);
        if (col >= H_VISIBLE || row >= V_VISIBLE) begin
            color = 12'h000;
            name  = "blanking";
        end else if (row == HUD_TOP - 1 || row == HUD_TOP) begin
            color = SEPARATOR_COLOR;
            name  = "hud_separator";
        end else if (row > HUD_TOP && col >= MINI_X0 && col < MINI_X1) begin
            name = "minimap";
            if (distance(mx, int'(p1_x)) <= DOT_HALF && distance(my, int'(p1_y)) <= DOT_HALF) begin
                color = P1_COLOR;
            end else if (distance(mx, int'(p2_x)) <= DOT_HALF
                         && distance(my, int'(p2_y)) <= DOT_HALF) begin
                color = P2_COLOR;
            end else begin
                color = TRACK_COLORS[track_copy[my * MAP_W + mx]];
            end
        end else if (row > HUD_TOP) begin
            color = HUD_COLOR;
            name  = "hud_background";
        end else if (col == HALF_WIDTH - 1 || col == HALF_WIDTH) begin
            color = SEPARATOR_COLOR;
            name  = "half_separator";
        end else if (distance(rel, SELF_CX) <= CAR_HALF && distance(row, SELF_CY) <= CAR_HALF) begin
            color = left ? P1_COLOR : P2_COLOR;
            name  = "self_car";
        end else if (distance(rel, cx) <= CAR_HALF && distance(row, cy) <= CAR_HALF) begin
            color = left ? P2_COLOR : P1_COLOR;
            name  = "rival_car";
        end else if (wc >= MAP_W || wr >= MAP_H) begin
            color = OUT_BOUND_COLOR;
            name  = "out_of_map";
        end else begin
            color = TRACK_COLORS[track_copy[wr * MAP_W + wc]];
            name  = "track_view";
        end
    endtask

    task automatic check_pixel();
        rgb_t  expected;
        rgb_t  actual;
        string name;
        model_pixel(scan_row, scan_col, expected, name);
        actual = {vga_red, vga_green, vga_blue};
        assert (actual == expected) else begin
            abort_run($sformatf("FAIL %s at row %0d col %0d expected %h actual %h",
                                name, scan_row, scan_col, expected, actual));
        end
    endtask

    // ========================================================================
    // scan position recovered from the port syncs, checked mid-cycle
    // ========================================================================
    always @(negedge clk_25MHz) begin
        cycles  = cycles + 1;
        vs_fell = 1'b0;
        if (col_known) begin
            if (scan_col == H_TOTAL - 1) begin
                scan_col = 0;
                scan_row = (scan_row == V_TOTAL - 1) ? 0 : scan_row + 1;
            end else begin
                scan_col = scan_col + 1;
            end
        end
        if (hs_prev && !hsync) begin
            scan_col  = H_SYNC_START;
            col_known = 1'b1;
        end
        if (vs_prev && !vsync) begin
            vs_fell   = 1'b1;
            scan_row  = V_SYNC_START;
            row_known = 1'b1;
            frames    = frames + 1;
        end
        hs_prev = hsync;
        vs_prev = vsync;
        if (cycles > CYCLE_LIMIT) begin
            abort_run($sformatf("timeout after %0d cycles without finishing", cycles));
        end else if (split_screen_top_inst.props_inst.violation) begin
            abort_run("a bound property on sync or blanking failed");
        end else if (vs_fell && scan_col != 0) begin
            abort_run("vsync fell away from the start of a line");
        end else if (row_known && loaded) begin
            check_pixel();
        end
    end

    initial begin
        map_index_t cls;
        int         addr;
        int         frame;
        void'($urandom(RAND_SEED));
        rst       = 1'b1;
        map_we    = 1'b0;
        map_addr  = '0;
        map_wdata = '0;
        p1_x      = SCENE_P1X[0];
        p1_y      = SCENE_P1Y[0];
        p2_x      = SCENE_P2X[0];
        p2_y      = SCENE_P2Y[0];
        repeat (4) @(posedge clk_25MHz);
        rst <= 1'b0;
        // random track classes, mirrored in the local copy
        for (addr = 0; addr < LOAD_CYCLES; addr++) begin
            cls              = map_index_t'($urandom_range(3, 0));
            track_copy[addr] = cls;
            map_we    <= 1'b1;
            map_addr  <= map_addr_t'(addr);
            map_wdata <= cls;
            @(posedge clk_25MHz);
        end
        map_we <= 1'b0;
        loaded = 1'b1;
        // new scene while vsync is low
        for (frame = 1; frame <= 3; frame++) begin
            wait (frames == frame);
            @(posedge clk_25MHz);
            p1_x <= SCENE_P1X[frame - 1];
            p1_y <= SCENE_P1Y[frame - 1];
            p2_x <= SCENE_P2X[frame - 1];
            p2_y <= SCENE_P2Y[frame - 1];
        end
        wait (frames == 4);
        if (split_screen_top_inst.props_inst.violation) begin
            abort_run("a bound property on sync or blanking failed");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- all.f
verilog/race_pkg.sv
verilog/scan_if.sv
verilog/layer_if.sv
verilog/vga_timing.sv
verilog/track_ram.sv
verilog/scan_decode.sv
verilog/layer_execute.sv
verilog/pixel_compose.sv
verilog/split_screen_top.sv
tests/split_screen_props.sv
tests/split_screen_tb.sv

//--- Makefile
TOP = split_screen_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
